// ==== files.f ====
src/bytecode_pkg.sv
src/exec_pkg.sv
src/opcode_decoder.sv
src/int_alu.sv
src/branch_unit.sv
src/local_var_file.sv
src/exec_sequencer.sv
src/bytecode_core.sv
testbench/tb_bytecode_core.sv

// ==== testbench/tb_bytecode_core.sv ====
`timescale 1ns/1ps

module tb_bytecode_core;
    import bytecode_pkg::*;
    import exec_pkg::*;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  arg1;
        logic [7:0]  arg2;
        logic [15:0] offset;    // expected next-instruction offset
        logic [7:0]  depth;     // expected stack depth afterwards
        word_t       top;       // expected top value, unused when depth is zero
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        op_valid;
    logic [7:0]  opcode;
    logic [7:0]  arg1;
    logic [7:0]  arg2;
    logic        op_done;
    logic [15:0] offset;
    logic        stack_push;
    logic        stack_trigger;
    word_t       stack_wdata;
    word_t       stack_rdata;
    logic        stack_done;

    row_t        rows[$];
    word_t       stack_q[$];    // back of the queue is the top of stack
    logic [31:0] lfsr;
    int          errors;
    int          model_errors;
    int          passed;
    int          failed;
    int          cycles;
    int          cycle_limit;

    bytecode_core #(.LVA_DEPTH(16)) dut_i (
        .clk(clk), .rst_n(rst_n), .op_valid(op_valid), .opcode(opcode),
        .arg1(arg1), .arg2(arg2), .op_done(op_done), .offset(offset),
        .stack_push(stack_push), .stack_trigger(stack_trigger),
        .stack_wdata(stack_wdata), .stack_rdata(stack_rdata), .stack_done(stack_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            d    = (d << 1) | int'(lfsr[0]);    // one step per bit
        end
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR time %0t %s expected %08h actual %08h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_row(input logic [7:0] op, input logic [7:0] a1, input logic [7:0] a2,
                           input logic [15:0] off, input int depth, input word_t top);
        rows.push_back({op, a1, a2, off, 8'(depth), top});
    endtask

    task automatic load_instruction_table();
        add_row(op_iconst_3,  8'h00, 8'h00, 16'h0001, 1, 32'h00000003);
        add_row(op_bipush,    8'hfe, 8'h00, 16'h0002, 2, 32'hfffffffe);
        add_row(op_sipush,    8'h12, 8'h34, 16'h0003, 3, 32'h00001234);
        add_row(op_iadd,      8'h00, 8'h00, 16'h0001, 2, 32'h00001232);
        add_row(op_isub,      8'h00, 8'h00, 16'h0001, 1, 32'hffffedd1);  // 3 - 0x1232
        add_row(op_sipush,    8'h01, 8'h00, 16'h0003, 2, 32'h00000100);
        add_row(op_imul,      8'h00, 8'h00, 16'h0001, 1, 32'hffedd100);  // wraps
        add_row(op_sipush,    8'h0f, 8'hf0, 16'h0003, 2, 32'h00000ff0);
        add_row(op_iand,      8'h00, 8'h00, 16'h0001, 1, 32'h00000100);
        add_row(op_bipush,    8'h33, 8'h00, 16'h0002, 2, 32'h00000033);
        add_row(op_ior,       8'h00, 8'h00, 16'h0001, 1, 32'h00000133);
        add_row(op_sipush,    8'hff, 8'h0f, 16'h0003, 2, 32'hffffff0f);
        add_row(op_ixor,      8'h00, 8'h00, 16'h0001, 1, 32'hfffffe3c);
        add_row(op_istore_1,  8'h00, 8'h00, 16'h0001, 0, 32'h00000000);
        add_row(op_iload_1,   8'h00, 8'h00, 16'h0001, 1, 32'hfffffe3c);
        add_row(op_istore,    8'h09, 8'h00, 16'h0002, 0, 32'h00000000);
        add_row(op_iload,     8'h09, 8'h00, 16'h0002, 1, 32'hfffffe3c);
        add_row(op_dup,       8'h00, 8'h00, 16'h0001, 2, 32'hfffffe3c);
        add_row(op_pop,       8'h00, 8'h00, 16'h0001, 1, 32'hfffffe3c);
        add_row(op_pop,       8'h00, 8'h00, 16'h0001, 0, 32'h00000000);
        add_row(op_iconst_0,  8'h00, 8'h00, 16'h0001, 1, 32'h00000000);
        add_row(op_ifeq,      8'h00, 8'h20, 16'h0020, 0, 32'h00000000);  // taken
        add_row(op_iconst_m1, 8'h00, 8'h00, 16'h0001, 1, 32'hffffffff);
        add_row(op_ifeq,      8'h00, 8'h20, 16'h0003, 0, 32'h00000000);
        add_row(op_iconst_m1, 8'h00, 8'h00, 16'h0001, 1, 32'hffffffff);
        add_row(op_iflt,      8'h01, 8'h00, 16'h0100, 0, 32'h00000000);  // taken
        add_row(op_iconst_5,  8'h00, 8'h00, 16'h0001, 1, 32'h00000005);
        add_row(op_iflt,      8'h01, 8'h00, 16'h0003, 0, 32'h00000000);
        add_row(op_iconst_5,  8'h00, 8'h00, 16'h0001, 1, 32'h00000005);
        add_row(op_ifgt,      8'hff, 8'hf0, 16'hfff0, 0, 32'h00000000);  // taken
        add_row(op_iconst_0,  8'h00, 8'h00, 16'h0001, 1, 32'h00000000);
        add_row(op_ifgt,      8'hff, 8'hf0, 16'h0003, 0, 32'h00000000);
        add_row(op_iconst_m1, 8'h00, 8'h00, 16'h0001, 1, 32'hffffffff);
        add_row(op_iconst_2,  8'h00, 8'h00, 16'h0001, 2, 32'h00000002);
        add_row(op_if_icmplt, 8'h00, 8'h40, 16'h0040, 0, 32'h00000000);  // -1 < 2
        add_row(op_iconst_4,  8'h00, 8'h00, 16'h0001, 1, 32'h00000004);
        add_row(op_iconst_1,  8'h00, 8'h00, 16'h0001, 2, 32'h00000001);
        add_row(op_if_icmplt, 8'h00, 8'h40, 16'h0003, 0, 32'h00000000);
        add_row(op_iconst_4,  8'h00, 8'h00, 16'h0001, 1, 32'h00000004);
        add_row(op_iconst_1,  8'h00, 8'h00, 16'h0001, 2, 32'h00000001);
        add_row(op_if_icmpge, 8'h00, 8'h50, 16'h0050, 0, 32'h00000000);  // 4 >= 1
        add_row(op_iconst_m1, 8'h00, 8'h00, 16'h0001, 1, 32'hffffffff);
        add_row(op_iconst_0,  8'h00, 8'h00, 16'h0001, 2, 32'h00000000);
        add_row(op_if_icmpge, 8'h00, 8'h50, 16'h0003, 0, 32'h00000000);
        add_row(op_iconst_2,  8'h00, 8'h00, 16'h0001, 1, 32'h00000002);
        add_row(op_goto,      8'h12, 8'h34, 16'h1234, 1, 32'h00000002);
        add_row(op_nop,       8'h00, 8'h00, 16'h0001, 1, 32'h00000002);
        add_row(op_sipush,    8'h00, 8'h07, 16'h0003, 2, 32'h00000007);
        add_row(8'hfe,        8'h00, 8'h00, 16'h0001, 2, 32'h00000007);  // undefined
    endtask

    // behavioral evaluation stack, answers 0 to 3 cycles late
    initial begin
        int    delay;
        logic  is_push;
        word_t data;
        stack_done  = 1'b0;
        stack_rdata = '0;
        forever begin
            @(negedge clk);
            stack_done = 1'b0;
            if (rst_n && stack_trigger) begin
                is_push = stack_push;
                data    = stack_wdata;
                draw_delay(delay);
                repeat (delay + 1) @(negedge clk);
                if (is_push) begin
                    stack_q.push_back(data);
                end else if (stack_q.size() == 0) begin
                    $display("stack model: pop from an empty stack at time %0t", $time);
                    model_errors++;
                    stack_rdata = '0;
                end else begin
                    stack_rdata = stack_q.pop_back();
                end
                stack_done = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the instruction table did not finish within %0d cycles", cycle_limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        row_t r;
        int   row_errors;
        op_valid     = 1'b0;
        opcode       = op_nop;
        arg1         = 8'h00;
        arg2         = 8'h00;
        rst_n        = 1'b0;
        lfsr         = 32'h1d5;
        errors       = 0;
        model_errors = 0;
        passed       = 0;
        failed       = 0;
        load_instruction_table();
        cycle_limit = rows.size() * 40 + 10;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare("op_done", op_done, 0);
        compare("offset", offset, 0);
        compare("stack_trigger", stack_trigger, 0);
        for (int i = 0; i < rows.size(); i++) begin
            r          = rows[i];
            row_errors = errors;
            @(negedge clk);
            opcode   = r.opcode;
            arg1     = r.arg1;
            arg2     = r.arg2;
            op_valid = 1'b1;
            @(negedge clk);
            op_valid = 1'b0;                    // core has left idle
            while (!op_done)
                @(negedge clk);
            compare("offset", offset, r.offset);
            compare("stack depth", stack_q.size(), r.depth);
            if (r.depth != 0)
                compare("stack top", stack_q[$], r.top);
            if (errors == row_errors) begin
                passed++;
                $display("row %0d opcode %02h offset %04h ok", i, r.opcode, offset);
            end else begin
                failed++;
                $display("row %0d opcode %02h mismatch", i, r.opcode);
            end
        end
        $display("rows passed %0d, rows failed %0d, stack model errors %0d",
                 passed, failed, model_errors);
        if (errors == 0 && model_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== src/bytecode_core.sv ====
`timescale 1ns/1ps

module bytecode_core #(
    parameter int LVA_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            op_valid,
    input  logic [7:0]      opcode,
    input  logic [7:0]      arg1,
    input  logic [7:0]      arg2,
    output logic            op_done,
    output logic [15:0]     offset,
    output logic            stack_push,
    output logic            stack_trigger,
    output exec_pkg::word_t stack_wdata,
    input  exec_pkg::word_t stack_rdata,
    input  logic            stack_done
);
    import bytecode_pkg::*;
    import exec_pkg::*;

    op_class_t                    op_class;
    alu_op_t                      alu_op;
    cmp_kind_t                    cmp_kind;
    logic                         cmp_two;
    word_t                        const_val;
    logic                         lva_implied;
    logic [1:0]                   lva_implied_index;
    logic [1:0]                   argc;
    logic [1:0]                   pops;
    logic                         writes_back;
    word_t                        operand_a;
    word_t                        operand_b;
    word_t                        alu_result;
    logic                         cmp_strobe;
    logic                         finish;
    logic                         lva_trigger;
    logic                         lva_write;
    logic [$clog2(LVA_DEPTH)-1:0] lva_index;
    word_t                        lva_wdata;
    word_t                        lva_rdata;
    logic                         lva_done;

    opcode_decoder decoder_i (
        .opcode(opcode), .op_class(op_class), .alu_op(alu_op), .cmp_kind(cmp_kind),
        .cmp_two(cmp_two), .const_val(const_val), .lva_implied(lva_implied),
        .lva_implied_index(lva_implied_index), .argc(argc), .pops(pops),
        .writes_back(writes_back)
    );

    exec_sequencer #(.LVA_DEPTH(LVA_DEPTH)) sequencer_i (
        .clk(clk), .rst_n(rst_n), .op_valid(op_valid), .arg1(arg1), .arg2(arg2),
        .op_class(op_class), .pops(pops), .argc(argc), .writes_back(writes_back),
        .const_val(const_val), .lva_implied(lva_implied),
        .lva_implied_index(lva_implied_index), .alu_result(alu_result),
        .operand_a(operand_a), .operand_b(operand_b), .cmp_strobe(cmp_strobe),
        .finish(finish), .op_done(op_done), .stack_push(stack_push),
        .stack_trigger(stack_trigger), .stack_wdata(stack_wdata),
        .stack_rdata(stack_rdata), .stack_done(stack_done), .lva_trigger(lva_trigger),
        .lva_write(lva_write), .lva_index(lva_index), .lva_wdata(lva_wdata),
        .lva_rdata(lva_rdata), .lva_done(lva_done)
    );

    int_alu alu_i (
        .operand_a(operand_a), .operand_b(operand_b), .alu_op(alu_op), .result(alu_result)
    );

    branch_unit branch_i (
        .clk(clk), .rst_n(rst_n), .operand_a(operand_a), .operand_b(operand_b),
        .cmp_kind(cmp_kind), .cmp_two(cmp_two), .cmp_strobe(cmp_strobe),
        .is_goto(op_class == cls_goto), .finish(finish), .argc(argc),
        .arg1(arg1), .arg2(arg2), .offset(offset)
    );

    local_var_file #(.LVA_DEPTH(LVA_DEPTH)) lva_i (
        .clk(clk), .rst_n(rst_n), .lva_trigger(lva_trigger), .lva_write(lva_write),
        .lva_index(lva_index), .lva_wdata(lva_wdata), .lva_rdata(lva_rdata),
        .lva_done(lva_done)
    );

endmodule

// ==== src/exec_sequencer.sv ====
`timescale 1ns/1ps

module exec_sequencer #(
    parameter int LVA_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         op_valid,
    input  logic [7:0]                   arg1,
    input  logic [7:0]                   arg2,
    input  bytecode_pkg::op_class_t      op_class,
    input  logic [1:0]                   pops,
    input  logic [1:0]                   argc,
    input  logic                         writes_back,
    input  exec_pkg::word_t              const_val,
    input  logic                         lva_implied,
    input  logic [1:0]                   lva_implied_index,
    input  exec_pkg::word_t              alu_result,
    output exec_pkg::word_t              operand_a,
    output exec_pkg::word_t              operand_b,
    output logic                         cmp_strobe,
    output logic                         finish,
    output logic                         op_done,
    output logic                         stack_push,
    output logic                         stack_trigger,
    output exec_pkg::word_t              stack_wdata,
    input  exec_pkg::word_t              stack_rdata,
    input  logic                         stack_done,
    output logic                         lva_trigger,
    output logic                         lva_write,
    output logic [$clog2(LVA_DEPTH)-1:0] lva_index,
    output exec_pkg::word_t              lva_wdata,
    input  exec_pkg::word_t              lva_rdata,
    input  logic                         lva_done
);
    import bytecode_pkg::*;
    import exec_pkg::*;

    localparam int IDX_W = $clog2(LVA_DEPTH);

    seq_state_t state;
    logic [1:0] pops_left;
    logic [1:0] push_left;                      // dup pushes twice
    word_t      wb_value;

    assign stack_trigger = (state == st_pop) || (state == st_push);
    assign stack_push    = (state == st_push) || (state == st_push_wait);
    assign lva_trigger   = (state == st_lva);
    assign lva_write     = (op_class == cls_lva_write);
    assign lva_index     = lva_implied ? IDX_W'(lva_implied_index) : arg1[IDX_W-1:0];
    assign lva_wdata     = operand_a;
    assign cmp_strobe    = (state == st_compare);
    assign finish        = ((state == st_exec) && !writes_back) ||
                           ((state == st_push_wait) && stack_done && (push_left == 2'd1));

    // value pushed back to the stack
    always_comb begin
        case (op_class)
            cls_const:    wb_value = const_val;
            cls_argpush:  wb_value = (argc == 2'd1) ? {{24{arg1[7]}}, arg1}
                                                    : {{16{arg1[7]}}, arg1, arg2};
            cls_alu:      wb_value = alu_result;
            cls_lva_read: wb_value = lva_rdata;
            default:      wb_value = operand_a;     // dup
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            op_done   <= 1'b0;
            pops_left <= 2'd0;
            push_left <= 2'd0;
        end else begin
            op_done <= finish;
            case (state)
                st_idle: begin
                    if (op_valid)
                        state <= st_decode;
                end
                st_decode: begin
                    pops_left <= pops;
                    if (pops != 2'd0)
                        state <= st_pop;
                    else if (op_class == cls_lva_read)
                        state <= st_lva;
                    else
                        state <= st_exec;
                end
                st_pop: state <= st_pop_wait;
                st_pop_wait: begin
                    if (stack_done) begin
                        pops_left <= pops_left - 2'd1;
                        if (pops_left != 2'd1)
                            state <= st_pop;
                        else if (op_class == cls_branch)
                            state <= st_compare;
                        else if (op_class == cls_lva_write)
                            state <= st_lva;
                        else
                            state <= st_exec;
                    end
                end
                st_lva: state <= st_lva_wait;
                st_lva_wait: begin
                    if (lva_done)
                        state <= st_exec;
                end
                st_compare: state <= st_exec;
                st_exec: begin
                    push_left <= (op_class == cls_dup) ? 2'd2 : 2'd1;
                    state     <= writes_back ? st_push : st_idle;
                end
                st_push: state <= st_push_wait;
                st_push_wait: begin
                    if (stack_done) begin
                        push_left <= push_left - 2'd1;
                        state     <= (push_left == 2'd1) ? st_idle : st_push;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // operands and push data
    always_ff @(posedge clk) begin
        if (state == st_pop_wait && stack_done) begin
            if (pops_left == 2'd2)
                operand_b <= stack_rdata;       // first of two pops is the top
            else
                operand_a <= stack_rdata;
        end
        if (state == st_exec)
            stack_wdata <= wb_value;
    end

    // the stack answers only an outstanding request
    assert property (@(posedge clk) disable iff (!rst_n)
        stack_done |-> ((state == st_pop_wait) || (state == st_push_wait)));

    // an explicit index byte must fit the variable file
    assert property (@(posedge clk) disable iff (!rst_n)
        lva_trigger && !lva_implied |-> 32'(arg1) < LVA_DEPTH);

endmodule

// ==== src/local_var_file.sv ====
`timescale 1ns/1ps

module local_var_file #(
    parameter int LVA_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         lva_trigger,
    input  logic                         lva_write,      // high for store
    input  logic [$clog2(LVA_DEPTH)-1:0] lva_index,
    input  exec_pkg::word_t              lva_wdata,
    output exec_pkg::word_t              lva_rdata,
    output logic                         lva_done
);
    import exec_pkg::*;

    word_t vars [LVA_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lva_done <= 1'b0;
            for (int i = 0; i < LVA_DEPTH; i++)
                vars[i] <= '0;
        end else begin
            lva_done <= lva_trigger;            // one-cycle answer
            if (lva_trigger && lva_write)
                vars[lva_index] <= lva_wdata;
        end
    end

    // read data holds until the next trigger
    always_ff @(posedge clk) begin
        if (lva_trigger)
            lva_rdata <= vars[lva_index];
    end

    // a second trigger may not overlap the pending answer
    assert property (@(posedge clk) disable iff (!rst_n) lva_trigger |=> !lva_trigger);

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  exec_pkg::word_t         operand_a,
    input  exec_pkg::word_t         operand_b,
    input  bytecode_pkg::cmp_kind_t cmp_kind,
    input  logic                    cmp_two,
    input  logic                    cmp_strobe,
    input  logic                    is_goto,
    input  logic                    finish,
    input  logic [1:0]              argc,
    input  logic [7:0]              arg1,
    input  logic [7:0]              arg2,
    output logic [15:0]             offset
);
    import bytecode_pkg::*;
    import exec_pkg::*;

    word_t rhs;
    logic  cond;
    logic  taken;

    assign rhs = cmp_two ? operand_b : '0;      // single-operand forms test against zero

    always_comb begin
        case (cmp_kind)
            cmp_eq:  cond = (operand_a == rhs);
            cmp_ne:  cond = (operand_a != rhs);
            cmp_lt:  cond = ($signed(operand_a) <  $signed(rhs));
            cmp_ge:  cond = ($signed(operand_a) >= $signed(rhs));
            cmp_gt:  cond = ($signed(operand_a) >  $signed(rhs));
            cmp_le:  cond = ($signed(operand_a) <= $signed(rhs));
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taken  <= 1'b0;
            offset <= 16'd0;
        end else begin
            if (cmp_strobe)
                taken <= cond;
            if (finish) begin
                taken  <= 1'b0;
                offset <= (is_goto || taken) ? {arg1, arg2} : {14'd0, argc} + 16'd1;
            end
        end
    end

endmodule

// ==== src/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  exec_pkg::word_t       operand_a,    // deeper stack value
    input  exec_pkg::word_t       operand_b,    // top of stack
    input  bytecode_pkg::alu_op_t alu_op,
    output exec_pkg::word_t       result
);
    import bytecode_pkg::*;

    always_comb begin
        case (alu_op)
            alu_add: result = operand_a + operand_b;
            alu_sub: result = operand_a - operand_b;
            alu_mul: result = operand_a * operand_b;    // low word only, wraps
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_xor: result = operand_a ^ operand_b;
            default: result = '0;
        endcase
    end

endmodule

// ==== src/opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
    input  logic [7:0]              opcode,
    output bytecode_pkg::op_class_t op_class,
    output bytecode_pkg::alu_op_t   alu_op,
    output bytecode_pkg::cmp_kind_t cmp_kind,
    output logic                    cmp_two,             // compare two stack values
    output exec_pkg::word_t         const_val,
    output logic                    lva_implied,         // index is part of the opcode
    output logic [1:0]              lva_implied_index,
    output logic [1:0]              argc,                // argument bytes after opcode
    output logic [1:0]              pops,                // stack values consumed
    output logic                    writes_back          // pushes a result
);
    import bytecode_pkg::*;
    import exec_pkg::*;

    always_comb begin
        op_class          = cls_other;
        alu_op            = alu_add;
        cmp_kind          = cmp_eq;
        cmp_two           = 1'b0;
        const_val         = '0;
        lva_implied       = 1'b0;
        lva_implied_index = 2'd0;
        argc              = 2'd0;
        pops              = 2'd0;
        writes_back       = 1'b0;
        case (opcode)
            op_iconst_m1, op_iconst_0, op_iconst_1, op_iconst_2,
            op_iconst_3, op_iconst_4, op_iconst_5: begin
                op_class    = cls_const;
                const_val   = word_t'(int'(opcode) - int'(op_iconst_0));  // m1 gives -1
                writes_back = 1'b1;
            end
            op_bipush, op_sipush: begin
                op_class    = cls_argpush;
                argc        = (opcode == op_bipush) ? 2'd1 : 2'd2;
                writes_back = 1'b1;
            end
            op_iload: begin
                op_class    = cls_lva_read;
                argc        = 2'd1;
                writes_back = 1'b1;
            end
            op_iload_0, op_iload_1, op_iload_2, op_iload_3: begin
                op_class          = cls_lva_read;
                lva_implied       = 1'b1;
                lva_implied_index = 2'(opcode - op_iload_0);
                writes_back       = 1'b1;
            end
            op_istore: begin
                op_class = cls_lva_write;
                argc     = 2'd1;
                pops     = 2'd1;
            end
            op_istore_0, op_istore_1, op_istore_2, op_istore_3: begin
                op_class          = cls_lva_write;
                lva_implied       = 1'b1;
                lva_implied_index = 2'(opcode - op_istore_0);
                pops              = 2'd1;
            end
            op_pop: begin
                op_class = cls_pop;
                pops     = 2'd1;
            end
            op_dup: begin
                op_class    = cls_dup;
                pops        = 2'd1;
                writes_back = 1'b1;             // pushed twice by the sequencer
            end
            op_iadd, op_isub, op_imul, op_iand, op_ior, op_ixor: begin
                op_class    = cls_alu;
                pops        = 2'd2;
                writes_back = 1'b1;
                case (opcode)
                    op_isub: alu_op = alu_sub;
                    op_imul: alu_op = alu_mul;
                    op_iand: alu_op = alu_and;
                    op_ior:  alu_op = alu_or;
                    op_ixor: alu_op = alu_xor;
                    default: alu_op = alu_add;
                endcase
            end
            op_ifeq, op_ifne, op_iflt, op_ifge, op_ifgt, op_ifle: begin
                op_class = cls_branch;
                cmp_kind = cmp_kind_t'(3'(opcode - op_ifeq));
                argc     = 2'd2;
                pops     = 2'd1;
            end
            op_if_icmpeq, op_if_icmpne, op_if_icmplt,
            op_if_icmpge, op_if_icmpgt, op_if_icmple: begin
                op_class = cls_branch;
                cmp_kind = cmp_kind_t'(3'(opcode - op_if_icmpeq));
                cmp_two  = 1'b1;
                argc     = 2'd2;
                pops     = 2'd2;
            end
            op_goto: begin
                op_class = cls_goto;
                argc     = 2'd2;
            end
            default: begin                      // nop and unknown opcodes
            end
        endcase
    end

endmodule

// ==== src/exec_pkg.sv ====
package exec_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;    // stack and local-variable word

    typedef enum logic [3:0] {
        st_idle,
        st_decode,
        st_pop,         // stack pop trigger
        st_pop_wait,
        st_lva,         // local-variable access trigger
        st_lva_wait,
        st_compare,
        st_exec,
        st_push,        // stack push trigger
        st_push_wait
    } seq_state_t;

endpackage

// ==== src/bytecode_pkg.sv ====
package bytecode_pkg;

    localparam logic [7:0] op_nop       = 8'h00;
    localparam logic [7:0] op_iconst_m1 = 8'h02;
    localparam logic [7:0] op_iconst_0  = 8'h03;
    localparam logic [7:0] op_iconst_1  = 8'h04;
    localparam logic [7:0] op_iconst_2  = 8'h05;
    localparam logic [7:0] op_iconst_3  = 8'h06;
    localparam logic [7:0] op_iconst_4  = 8'h07;
    localparam logic [7:0] op_iconst_5  = 8'h08;
    localparam logic [7:0] op_bipush    = 8'h10;
    localparam logic [7:0] op_sipush    = 8'h11;
    localparam logic [7:0] op_iload     = 8'h15;
    localparam logic [7:0] op_iload_0   = 8'h1a;
    localparam logic [7:0] op_iload_1   = 8'h1b;
    localparam logic [7:0] op_iload_2   = 8'h1c;
    localparam logic [7:0] op_iload_3   = 8'h1d;
    localparam logic [7:0] op_istore    = 8'h36;
    localparam logic [7:0] op_istore_0  = 8'h3b;
    localparam logic [7:0] op_istore_1  = 8'h3c;
    localparam logic [7:0] op_istore_2  = 8'h3d;
    localparam logic [7:0] op_istore_3  = 8'h3e;
    localparam logic [7:0] op_pop       = 8'h57;
    localparam logic [7:0] op_dup       = 8'h59;
    localparam logic [7:0] op_iadd      = 8'h60;
    localparam logic [7:0] op_isub      = 8'h64;
    localparam logic [7:0] op_imul      = 8'h68;
    localparam logic [7:0] op_iand      = 8'h7e;
    localparam logic [7:0] op_ior       = 8'h80;
    localparam logic [7:0] op_ixor      = 8'h82;
    localparam logic [7:0] op_ifeq      = 8'h99;
    localparam logic [7:0] op_ifne      = 8'h9a;
    localparam logic [7:0] op_iflt      = 8'h9b;
    localparam logic [7:0] op_ifge      = 8'h9c;
    localparam logic [7:0] op_ifgt      = 8'h9d;
    localparam logic [7:0] op_ifle      = 8'h9e;
    localparam logic [7:0] op_if_icmpeq = 8'h9f;
    localparam logic [7:0] op_if_icmpne = 8'ha0;
    localparam logic [7:0] op_if_icmplt = 8'ha1;
    localparam logic [7:0] op_if_icmpge = 8'ha2;
    localparam logic [7:0] op_if_icmpgt = 8'ha3;
    localparam logic [7:0] op_if_icmple = 8'ha4;
    localparam logic [7:0] op_goto      = 8'ha7;

    // order matches the ifeq..ifle opcode sequence
    typedef enum logic [2:0] {cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_gt, cmp_le} cmp_kind_t;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_mul, alu_and, alu_or, alu_xor} alu_op_t;

    typedef enum logic [3:0] {
        cls_const, cls_argpush, cls_alu, cls_lva_read, cls_lva_write,
        cls_pop, cls_dup, cls_goto, cls_branch, cls_other
    } op_class_t;

endpackage
